// File: design/write_path_consts.svh
`ifndef WRITE_PATH_CONSTS_SVH
`define WRITE_PATH_CONSTS_SVH

// data path word.
`define WORD_WIDTH 32

// 1024 words of data memory.
`define ADDR_WIDTH 10

// output window at the top of the address space.
`define IO_PORT_COUNT 4
`define IO_PORT_ADDR_WIDTH 2

// first address of the window that runs to 1023.
`define IO_BASE_ADDR 1020

`endif

// File: design/write_path_pkg.sv
`include "write_path_consts.svh"

package write_path_pkg;

    // store request as registered toward the data RAM.
    typedef struct packed {
        logic                   wren;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`WORD_WIDTH-1:0] data;
    } write_req_t;

    // one address word seen whole for the window compare
    // or split after the window base has been taken off.
    typedef union packed {
        logic [`ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [`ADDR_WIDTH-`IO_PORT_ADDR_WIDTH-1:0] upper;
            logic [`IO_PORT_ADDR_WIDTH-1:0]             port;
        } split;
    } io_addr_u;

    // port write enables and the shared port data.
    typedef struct packed {
        logic [`IO_PORT_COUNT-1:0] wren; // one-hot or zero.
        logic [`WORD_WIDTH-1:0]    data;
    } io_bus_t;

endpackage

// File: design/io_write_port.sv
`timescale 1ns/1ps
`include "write_path_consts.svh"

module io_write_port
    import write_path_pkg::*;
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   wren,
    input  logic [`ADDR_WIDTH-1:0] write_addr,
    input  logic [`WORD_WIDTH-1:0] write_data,
    output write_req_t             ram_req,
    output io_bus_t                io_bus
);

    localparam logic [`ADDR_WIDTH-1:0] IO_FIRST = `ADDR_WIDTH'(`IO_BASE_ADDR);
    localparam logic [`ADDR_WIDTH-1:0] IO_LAST  =
        `ADDR_WIDTH'(`IO_BASE_ADDR + `IO_PORT_COUNT - 1);

    io_addr_u                  req_addr;
    io_addr_u                  port_offset;
    logic                      in_window;
    logic [`IO_PORT_COUNT-1:0] port_sel;

    // every store goes to RAM as it came in.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ram_req.wren <= 1'b0;
        end else begin
            ram_req.wren <= wren;
        end
    end

    always_ff @(posedge clock) begin
        ram_req.addr <= write_addr;
        ram_req.data <= write_data;
    end

    // window check on the raw address.
    always_comb begin
        req_addr.raw = write_addr;
        in_window    = (req_addr.raw >= IO_FIRST) && (req_addr.raw <= IO_LAST);
    end

    // translate to a port index relative to the window base.
    always_comb begin
        port_offset.raw = req_addr.raw - IO_FIRST;
        port_sel        = '0;
        if (wren && in_window) begin
            port_sel[port_offset.split.port] = 1'b1; // one port only.
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_bus.wren <= '0;
        end else begin
            io_bus.wren <= port_sel;
        end
    end

    // the data word is shared by all ports.
    always_ff @(posedge clock) begin
        io_bus.data <= write_data;
    end

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ps
`include "write_path_consts.svh"

module data_ram
    import write_path_pkg::*;
(
    input  logic                   clock,
    input  write_req_t             ram_req,
    input  logic [`ADDR_WIDTH-1:0] read_addr,
    output logic [`WORD_WIDTH-1:0] read_data
);

    localparam int DEPTH = 1 << `ADDR_WIDTH;

    logic [`WORD_WIDTH-1:0] mem [DEPTH];

    // write port, fed by the registered request.
    always_ff @(posedge clock) begin
        if (ram_req.wren) begin
            mem[ram_req.addr] <= ram_req.data;
        end
    end

    // registered read.
    // a read and write to the same word on one edge returns the old word.
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

// File: design/io_out_latch.sv
`timescale 1ns/1ps
`include "write_path_consts.svh"

module io_out_latch
    import write_path_pkg::*;
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  io_bus_t                   io_bus,
    output logic [`WORD_WIDTH-1:0]    port_data [`IO_PORT_COUNT],
    output logic [`IO_PORT_COUNT-1:0] port_update
);

    // one holding register per port.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `IO_PORT_COUNT; i++) begin
                port_data[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `IO_PORT_COUNT; i++) begin
                if (io_bus.wren[i]) begin
                    port_data[i] <= io_bus.data; // load, else hold.
                end
            end
        end
    end

    // strobe lines up with the new port value.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            port_update <= '0;
        end else begin
            port_update <= io_bus.wren;
        end
    end

endmodule

// File: design/write_path_top.sv
`timescale 1ns/1ps
`include "write_path_consts.svh"

module write_path_top
    import write_path_pkg::*;
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      wren,
    input  logic [`ADDR_WIDTH-1:0]    write_addr,
    input  logic [`WORD_WIDTH-1:0]    write_data,
    input  logic [`ADDR_WIDTH-1:0]    read_addr,
    output logic [`WORD_WIDTH-1:0]    read_data,
    output logic [`WORD_WIDTH-1:0]    port_data [`IO_PORT_COUNT],
    output logic [`IO_PORT_COUNT-1:0] port_update
);

    write_req_t ram_req; // producer to RAM.
    io_bus_t    io_bus;  // producer to output latch.

    // registers each store and decodes the output window.
    io_write_port io_write_port_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .wren       (wren),
        .write_addr (write_addr),
        .write_data (write_data),
        .ram_req    (ram_req),
        .io_bus     (io_bus)
    );

    data_ram data_ram_inst (
        .clock     (clock),
        .ram_req   (ram_req),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    io_out_latch io_out_latch_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .io_bus      (io_bus),
        .port_data   (port_data),
        .port_update (port_update)
    );

endmodule

// File: testbench/write_path_checker.sv
`timescale 1ns/1ps
`include "write_path_consts.svh"

module write_path_checker (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      wren,
    input  logic [`ADDR_WIDTH-1:0]    write_addr,
    input  logic [`WORD_WIDTH-1:0]    write_data,
    input  logic [`ADDR_WIDTH-1:0]    read_addr,
    input  logic [`WORD_WIDTH-1:0]    read_data,
    input  logic [`WORD_WIDTH-1:0]    port_data [`IO_PORT_COUNT],
    input  logic [`IO_PORT_COUNT-1:0] port_update,
    input  logic                      read_check,
    input  logic [`WORD_WIDTH-1:0]    read_expect,
    input  logic                      test_end,
    input  int                        test_num,
    output int                        checks,
    output int                        errors,
    output int                        tests
);

    localparam int DEPTH = 1 << `ADDR_WIDTH;

    logic [`WORD_WIDTH-1:0]    model_mem [DEPTH];
    logic [DEPTH-1:0]          model_valid = '0;
    logic [`WORD_WIDTH-1:0]    model_port [`IO_PORT_COUNT];
    logic [`IO_PORT_COUNT-1:0] model_update;
    logic                      stage_wren; // request sampled at the previous edge.
    logic [`ADDR_WIDTH-1:0]    stage_addr;
    logic [`WORD_WIDTH-1:0]    stage_data;
    logic                      read_pending = 1'b0;
    logic [`ADDR_WIDTH-1:0]    read_at;
    logic [`WORD_WIDTH-1:0]    file_word;
    logic [`WORD_WIDTH-1:0]    model_word;
    logic                      model_word_ok;
    logic                      seen_reset = 1'b0;
    int                        check_total = 0;
    int                        error_total = 0;
    int                        test_total = 0;
    int                        error_mark = 0;

    assign checks = check_total;
    assign errors = error_total;
    assign tests  = test_total;

    // window runs from the base up to but not including base plus port count.
    function automatic bit in_window(input logic [`ADDR_WIDTH-1:0] addr);
        return (int'(addr) >= `IO_BASE_ADDR) && (int'(addr) < `IO_BASE_ADDR + `IO_PORT_COUNT);
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        error_total++;
    endtask

    // model steps on each rising edge from the DUT inputs only.
    always @(posedge clock) begin : model_step
        int idx;
        if (!rst_n) begin
            seen_reset   = 1'b1;
            stage_wren   = 1'b0;
            read_pending = 1'b0;
            model_update = '0;
            for (int k = 0; k < `IO_PORT_COUNT; k++) begin
                model_port[k] = '0;
            end
        end else begin
            read_pending = read_check;
            if (read_check) begin // old word if written on this edge.
                read_at       = read_addr;
                file_word     = read_expect;
                model_word    = model_mem[read_addr];
                model_word_ok = model_valid[read_addr];
            end
            model_update = '0;
            if (stage_wren) begin
                model_mem[stage_addr]   = stage_data;
                model_valid[stage_addr] = 1'b1;
                if (in_window(stage_addr)) begin
                    idx = int'(stage_addr) - `IO_BASE_ADDR;
                    model_port[idx]   = stage_data;
                    model_update[idx] = 1'b1;
                end
            end
            stage_wren = wren;
            stage_addr = write_addr;
            stage_data = write_data;
            if (test_end) begin
                if (error_total == error_mark) begin
                    $display("test %0d finished: passed", test_num);
                end else begin
                    $display("test %0d finished: %0d errors", test_num, error_total - error_mark);
                end
                error_mark = error_total;
                test_total++;
            end
        end
    end

    // outputs are settled by the falling edge.
    always @(negedge clock) begin
        if (seen_reset) begin
            for (int k = 0; k < `IO_PORT_COUNT; k++) begin
                check_total++;
                if (port_data[k] !== model_port[k]) begin
                    report_error($sformatf("port %0d holds %h, expected %h",
                        k, port_data[k], model_port[k]));
                end
            end
            check_total++;
            if (port_update !== model_update) begin
                report_error($sformatf("port_update is %b, expected %b",
                    port_update, model_update));
            end
            if (read_pending) begin
                check_total++;
                if (read_data !== file_word) begin
                    report_error($sformatf("read at %h gave %h, expected %h",
                        read_at, read_data, file_word));
                end
                if (model_word_ok && (file_word !== model_word)) begin
                    report_error($sformatf("vector expects %h at %h, model holds %h",
                        file_word, read_at, model_word));
                end
            end
        end
    end

endmodule

// File: testbench/tb_write_path.sv
`timescale 1ns/1ps
`include "write_path_consts.svh"

module tb_write_path;

    localparam int          CLOCK_PERIOD = 10;
    localparam int          MAX_LINES    = 256;
    localparam logic [31:0] CMD_WRITE    = 32'h1;
    localparam logic [31:0] CMD_NO_WREN  = 32'h2;
    localparam logic [31:0] CMD_READ     = 32'h3;
    localparam logic [31:0] CMD_END_TEST = 32'h4;

    logic                      clock;
    logic                      rst_n;
    logic                      wren;
    logic [`ADDR_WIDTH-1:0]    write_addr;
    logic [`WORD_WIDTH-1:0]    write_data;
    logic [`ADDR_WIDTH-1:0]    read_addr;
    logic [`WORD_WIDTH-1:0]    read_data;
    logic [`WORD_WIDTH-1:0]    port_data [`IO_PORT_COUNT];
    logic [`IO_PORT_COUNT-1:0] port_update;
    logic                      read_check;
    logic [`WORD_WIDTH-1:0]    read_expect;
    logic                      test_end;
    int                        test_num;
    int                        checks;
    int                        errors;
    int                        tests;
    logic [31:0]               vectors [3*MAX_LINES]; // cmd, addr, data per line.
    int                        line_count;
    int                        bad_lines = 0;
    bit                        loaded = 1'b0;

    write_path_top write_path_top_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .wren        (wren),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .port_data   (port_data),
        .port_update (port_update)
    );

    write_path_checker write_path_checker_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .wren        (wren),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .port_data   (port_data),
        .port_update (port_update),
        .read_check  (read_check),
        .read_expect (read_expect),
        .test_end    (test_end),
        .test_num    (test_num),
        .checks      (checks),
        .errors      (errors),
        .tests       (tests)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic clear_inputs();
        wren        = 1'b0;
        write_addr  = '0;
        write_data  = '0;
        read_check  = 1'b0;
        read_expect = '0;
        test_end    = 1'b0;
    endtask

    task automatic load_vectors(output int count);
        for (int i = 0; i < 3 * MAX_LINES; i++) begin
            vectors[i] = '1; // marks the end of the file.
        end
        $readmemh("testbench/write_path_vectors.txt", vectors);
        count = 0;
        while (count < MAX_LINES && vectors[3 * count] != '1) begin
            count++;
        end
    endtask

    // drives one command line from a falling edge.
    task automatic drive_line(input int idx);
        logic [31:0] cmd;
        logic [31:0] addr;
        logic [31:0] data;
        cmd  = vectors[3 * idx];
        addr = vectors[3 * idx + 1];
        data = vectors[3 * idx + 2];
        @(negedge clock);
        clear_inputs();
        case (cmd)
            CMD_WRITE: begin
                wren       = 1'b1;
                write_addr = addr[`ADDR_WIDTH-1:0];
                write_data = data;
            end
            CMD_NO_WREN: begin
                write_addr = addr[`ADDR_WIDTH-1:0];
                write_data = data;
            end
            CMD_READ: begin
                read_addr   = addr[`ADDR_WIDTH-1:0];
                read_check  = 1'b1;
                read_expect = data;
            end
            CMD_END_TEST: begin
                repeat (3) @(negedge clock); // let the pipeline drain.
                test_num = int'(addr);
                test_end = 1'b1;
            end
            default: begin
                $display("vector line %0d has an unknown command %h", idx, cmd);
                bad_lines++;
            end
        endcase
    endtask

    initial begin
        rst_n     = 1'b0;
        read_addr = '0;
        test_num  = 0;
        clear_inputs();
        load_vectors(line_count);
        if (line_count == 0) begin
            $display("no command lines were read from the vector file");
            $display("Done: errors found");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (3) @(negedge clock);
            rst_n = 1'b1;
            for (int i = 0; i < line_count; i++) begin
                drive_line(i);
            end
            @(negedge clock);
            clear_inputs();
            repeat (2) @(negedge clock);
            $display("%0d tests, %0d checks, %0d errors, %0d bad vector lines",
                tests, checks, errors, bad_lines);
            if (errors == 0 && bad_lines == 0 && tests > 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    // budget of 4 cycles per vector line plus 50.
    initial begin
        wait (loaded);
        #((line_count * 4 + 50) * CLOCK_PERIOD);
        $display("the run timed out after %0d cycles", line_count * 4 + 50);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: testbench/write_path_vectors.txt
// columns: cmd addr data, in hex. cmd 1 write, 2 request with wren low,
// 3 read addr and expect data, 4 end of test with addr as the test number.
4 001 00000000
1 000 11111111
1 001 22222222
1 3fb 33333333
1 155 a5a5a5a5
3 000 11111111
3 001 22222222
3 3fb 33333333
3 155 a5a5a5a5
4 002 00000000
1 3fc 0000000a
1 3fd 0000000b
1 3fe 0000000c
1 3ff 0000000d
4 003 00000000
3 3fc 0000000a
3 3ff 0000000d
4 004 00000000
1 3fd 12345678
1 010 cafef00d
1 3fd 87654321
1 011 0badbeef
1 3fe 5555aaaa
1 010 deadbeef
3 011 0badbeef
3 010 deadbeef
3 3fd 87654321
4 005 00000000
2 3fe ffffffff
2 010 00000000
2 3fc 99999999
3 010 deadbeef
3 3fc 0000000a
4 006 00000000

// File: src.f
+incdir+design
design/write_path_pkg.sv
design/io_write_port.sv
design/data_ram.sv
design/io_out_latch.sv
design/write_path_top.sv
testbench/write_path_checker.sv
testbench/tb_write_path.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_write_path
FILELIST  := src.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/write_path_consts.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
